/* Bender.yml */
package:
  name: nes_loader

sources:
  - nes_pkg.sv
  - loader_if.sv
  - ines_header_decoder.sv
  - rom_loader.sv
  - machine_ctrl.sv
  - joypad_serial.sv
  - nes_loader_top.sv
  - target: test
    files:
      - tb_nes_loader.sv

/* flist.f */
nes_pkg.sv
loader_if.sv
ines_header_decoder.sv
rom_loader.sv
machine_ctrl.sv
joypad_serial.sv
nes_loader_top.sv
tb_nes_loader.sv

/* ines_header_decoder.sv */
/*
 * iNES header decoder
 * Stores the sixteen header bytes and decodes validity, ROM page counts
 * and the mapper flags word, with NES 2.0 and dirty header handling
 */
`timescale 1ns/1ps

module ines_header_decoder (
	input  logic                   clk,
	input  logic                   hdr_wr,
	input  logic [3:0]             hdr_index,
	input  nes_pkg::byte_t         hdr_byte,
	input  logic                   invert_mirroring,
	output nes_pkg::byte_t         prg_pages,
	output nes_pkg::byte_t         chr_pages,
	output logic                   header_ok,
	output nes_pkg::mapper_flags_t flags
);

	nes_pkg::byte_t hdr [nes_pkg::HEADER_LEN];

	logic is_nes20;
	logic is_dirty;

	// Page count to size code, thresholds double per step
	function automatic nes_pkg::size_code_t size_code(input nes_pkg::byte_t pages);
		if (pages <= 8'd1)
			return 3'd0;
		else if (pages <= 8'd2)
			return 3'd1;
		else if (pages <= 8'd4)
			return 3'd2;
		else if (pages <= 8'd8)
			return 3'd3;
		else if (pages <= 8'd16)
			return 3'd4;
		else if (pages <= 8'd32)
			return 3'd5;
		else if (pages <= 8'd64)
			return 3'd6;
		else
			return 3'd7;
	endfunction

	always_ff @(posedge clk) begin
		if (hdr_wr)
			hdr[hdr_index] <= hdr_byte;
	end

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];

	// Trainers are not supported
	assign header_ok = ({hdr[0], hdr[1], hdr[2], hdr[3]} == nes_pkg::INES_MAGIC) && !hdr[6][2];

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old dumps often carry text in bytes 8 to 15
	always_comb begin
		is_dirty = 1'b0;
		for (int i = 8; i < nes_pkg::HEADER_LEN; i++) begin
			if (hdr[i] != 8'h00)
				is_dirty = 1'b1;
		end
		if (is_nes20)
			is_dirty = 1'b0;
	end

	always_comb begin
		flags.reserved     = '0;
		flags.ines2_mapper = is_nes20 ? hdr[8] : 8'h00;
		flags.four_screen  = hdr[6][3];
		flags.chr_ram      = (chr_pages == 8'd0);
		flags.mirroring    = hdr[6][0] ^ invert_mirroring;
		flags.chr_size     = size_code(chr_pages);
		flags.prg_size     = size_code(prg_pages);
		flags.mapper       = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	end

endmodule

/* joypad_serial.sv */
/*
 * Serial joypad ports
 * Two controller shift registers loaded from host button bytes
 */
`timescale 1ns/1ps

module joypad_serial (
	input  logic           clk,
	input  logic           nes_reset,
	input  nes_pkg::byte_t joy_a,
	input  nes_pkg::byte_t joy_b,
	input  logic           joy_swap,
	input  logic           joypad_strobe,
	input  logic [1:0]     joypad_clock,
	output logic [1:0]     joypad_data
);

	nes_pkg::byte_t shreg [2];
	nes_pkg::byte_t pad_a;
	nes_pkg::byte_t pad_b;
	logic [1:0]     last_clock;

	// Host order to NES order, buttons first and directions reversed
	function automatic nes_pkg::byte_t nes_order(input nes_pkg::byte_t host);
		return {host[0], host[1], host[2], host[3], host[7], host[6], host[5], host[4]};
	endfunction

	assign pad_a = nes_order(joy_a);
	assign pad_b = nes_order(joy_b);

	always_ff @(posedge clk) begin
		if (nes_reset) begin
			shreg[0]   <= 8'h00;
			shreg[1]   <= 8'h00;
			last_clock <= 2'b00;
		end else begin
			if (joypad_strobe) begin
				shreg[0] <= joy_swap ? pad_a : pad_b; // Player B on port 0
				shreg[1] <= joy_swap ? pad_b : pad_a;
			end
			// Falling edge of each clock line moves to the next button
			for (int n = 0; n < 2; n++) begin
				if (last_clock[n] && !joypad_clock[n])
					shreg[n] <= {1'b0, shreg[n][7:1]};
			end
			last_clock <= joypad_clock;
		end
	end

	assign joypad_data = {shreg[1][0], shreg[0][0]};

endmodule

/* loader_if.sv */
/*
 * Loader to machine control link
 * Raw write requests and the load result of the cartridge loader
 */
`timescale 1ns/1ps

interface loader_if;

	nes_pkg::mem_addr_t     wr_addr;
	nes_pkg::byte_t         wr_data;
	logic                   wr_req;  // Single cycle, address and data valid with it
	nes_pkg::mapper_flags_t flags;
	logic                   done;    // Level, held until the loader is cleared
	logic                   error;

	modport source (
		output wr_addr, wr_data, wr_req, flags, done, error
	);

	modport sink (
		input wr_addr, wr_data, wr_req, flags, done, error
	);

endinterface

/* machine_ctrl.sv */
/*
 * Machine control
 * Enable strobe, machine reset sequencing around downloads, staging of
 * loader writes onto the enable phase and latching of the load result
 */
`timescale 1ns/1ps

module machine_ctrl (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   downloading,
	loader_if.sink                 ld,
	output logic                   loader_clear,
	output logic                   nes_ce,
	output logic                   nes_reset,
	output nes_pkg::mem_addr_t     mem_addr,
	output nes_pkg::byte_t         mem_data,
	output logic                   mem_write,
	output nes_pkg::mapper_flags_t mapper_flags,
	output logic                   load_error
);

	logic [1:0] phase;
	logic       init_reset; // Set until the first download begins
	logic [7:0] dl_cnt;     // Hold after a download
	logic       wr_pending;

	assign nes_ce = (phase == nes_pkg::CE_PHASE_LAST);

	// Loader starts over once the hold is over and the host is idle
	assign loader_clear = (dl_cnt == 8'd0) && !downloading;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase      <= 2'd0;
			init_reset <= 1'b1;
			dl_cnt     <= 8'd0;
			nes_reset  <= 1'b1;
		end else begin
			phase <= phase + 2'd1; // Runs through reset too
			if (downloading)
				init_reset <= 1'b0;
			if (downloading)
				dl_cnt <= nes_pkg::DL_RESET_HOLD;
			else if (dl_cnt != 8'd0)
				dl_cnt <= dl_cnt - 8'd1;
			nes_reset <= init_reset || downloading || (dl_cnt != 8'd0) || load_error;
		end
	end

	// Write waits for the next enable phase, then goes out for one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_pending <= 1'b0;
			mem_write  <= 1'b0;
			load_error <= 1'b0;
		end else begin
			if (ld.wr_req)
				wr_pending <= 1'b1;
			else if (nes_ce)
				wr_pending <= 1'b0;
			mem_write <= nes_ce && wr_pending;
			if (ld.done)
				load_error <= ld.error;
			else if (downloading)
				load_error <= 1'b0; // New image on its way
		end
	end

	always_ff @(posedge clk) begin
		if (ld.wr_req) begin
			mem_addr <= ld.wr_addr;
			mem_data <= ld.wr_data;
		end
		if (ld.done)
			mapper_flags <= ld.flags;
	end

endmodule

/* nes_loader_golden.hex */
// Record line: byte count, invert_mirroring, expected error, expected mapper_flags
// Then the image bytes, header first; a zero byte count ends the file
// Plain image, mapper 21, vertical mirroring
28 0 0 00004021
4E 45 53 1A 01 01 11 20 00 00 00 00 00 00 00 00
A0 A1 A2 A3 A4 A5 A6 A7 A8 A9 AA AB AC AD AE AF
C0 C1 C2 C3 C4 C5 C6 C7
// Text in bytes 8 to 15 drops the upper mapper nibble, two PRG pages
38 0 0 00000104
4E 45 53 1A 02 01 40 30 44 69 73 6B 44 75 64 65
5A 3C 96 E1 07 F0 0F 81 42 24 18 7E 99 66 C3 3C
01 02 04 08 10 20 40 80 FE FD FB F7 EF DF BF 7F
D0 D1 D2 D3 D4 D5 D6 D7
// Bad magic, trailing bytes must not be written
18 0 1 00000000
4E 45 53 00 01 01 00 00 00 00 00 00 00 00 00 00
11 22 33 44 55 66 77 88
// NES 2.0 with extended mapper byte and two CHR pages
30 0 0 00060815
4E 45 53 1A 01 02 50 18 03 00 07 00 00 00 00 00
00 FF 55 AA 33 CC 0F F0 12 34 56 78 9A BC DE F0
E0 E1 E2 E3 E4 E5 E6 E7 E8 E9 EA EB EC ED EE EF
// Trainer present
18 0 1 00000002
4E 45 53 1A 01 01 24 00 00 00 00 00 00 00 00 00
60 61 62 63 64 65 66 67
// No CHR pages and four screen layout
20 0 0 00018007
4E 45 53 1A 01 00 78 00 00 00 00 00 00 00 00 00
3A 3B 3C 3D 3E 3F 40 41 42 43 44 45 46 47 48 49
// Mirroring flipped by invert_mirroring, mapper 49
28 1 0 00004049
4E 45 53 1A 01 01 90 40 00 00 00 00 00 00 00 00
80 7F 81 7E 82 7D 83 7C 84 7B 85 7A 86 79 87 78
B8 B9 BA BB BC BD BE BF
// End of images
0

/* nes_loader_top.sv */
/*
 * NES cartridge loader and machine control top level
 * Host byte stream in, staged memory writes, flags and reset out
 */
`timescale 1ns/1ps

module nes_loader_top #(
	parameter int PRG_PAGE_BITS = 14,
	parameter int CHR_PAGE_BITS = 13
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   downloading,
	input  nes_pkg::byte_t         dl_data,
	input  logic                   dl_wr,
	input  logic                   invert_mirroring,
	input  nes_pkg::byte_t         joy_a,
	input  nes_pkg::byte_t         joy_b,
	input  logic                   joy_swap,
	input  logic                   joypad_strobe,
	input  logic [1:0]             joypad_clock,
	output logic                   nes_ce,
	output logic                   nes_reset,
	output nes_pkg::mem_addr_t     mem_addr,
	output nes_pkg::byte_t         mem_data,
	output logic                   mem_write,
	output nes_pkg::mapper_flags_t mapper_flags,
	output logic                   load_error,
	output logic [1:0]             joypad_data
);

	loader_if ld ();

	logic loader_clear;

	rom_loader #(
		.PRG_PAGE_BITS (PRG_PAGE_BITS),
		.CHR_PAGE_BITS (CHR_PAGE_BITS)
	) rom_loader_inst (
		.clk              (clk),
		.loader_clear     (loader_clear),
		.downloading      (downloading),
		.dl_data          (dl_data),
		.dl_wr            (dl_wr),
		.invert_mirroring (invert_mirroring),
		.ld               (ld.source)
	);

	machine_ctrl machine_ctrl_inst (
		.clk          (clk),
		.reset        (reset),
		.downloading  (downloading),
		.ld           (ld.sink),
		.loader_clear (loader_clear),
		.nes_ce       (nes_ce),
		.nes_reset    (nes_reset),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.mem_write    (mem_write),
		.mapper_flags (mapper_flags),
		.load_error   (load_error)
	);

	joypad_serial joypad_serial_inst (
		.clk           (clk),
		.nes_reset     (nes_reset),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_swap      (joy_swap),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data)
	);

endmodule

/* nes_pkg.sv */
/*
 * NES loader shared definitions
 * Memory address and byte types, the mapper flags word, loader states
 * and the constants used by the loader and machine control
 */
package nes_pkg;

	// Memory byte address, PRG at the bottom and CHR from CHR_BASE
	typedef logic [21:0] mem_addr_t;

	typedef logic [7:0] byte_t;

	// Power-of-two ROM size, 0 is one page or less, 7 is above 64 pages
	typedef logic [2:0] size_code_t;

	// Flags word handed to the machine, most significant field first
	typedef struct packed {
		logic [6:0] reserved;     // Always zero
		byte_t      ines2_mapper; // NES 2.0 extended mapper byte
		logic       four_screen;
		logic       chr_ram;      // No CHR ROM in the image
		logic       mirroring;
		size_code_t chr_size;
		size_code_t prg_size;
		byte_t      mapper;
	} mapper_flags_t;

	typedef enum logic [2:0] {
		HEADER,
		PRG,
		CHR,
		LOADED,
		BAD_IMAGE
	} loader_state_e;

	// "NES" followed by MS-DOS end of file
	localparam logic [31:0] INES_MAGIC = 32'h4E45_531A;

	localparam int HEADER_LEN = 16;

	// First CHR byte in memory
	localparam mem_addr_t CHR_BASE = 22'h200000;

	// Machine stays in reset this many cycles once a download ends
	localparam logic [7:0] DL_RESET_HOLD = 8'd255;

	// Four enable phases, the strobe fires in the last one
	localparam logic [1:0] CE_PHASE_LAST = 2'd3;

endpackage

/* rom_loader.sv */
/*
 * Cartridge image loader
 * Walks the header, PRG and CHR sections of an iNES image and turns each
 * host byte into a write request at its memory address
 */
`timescale 1ns/1ps

module rom_loader #(
	parameter int PRG_PAGE_BITS = 14,
	parameter int CHR_PAGE_BITS = 13
) (
	input  logic           clk,
	input  logic           loader_clear,
	input  logic           downloading,
	input  nes_pkg::byte_t dl_data,
	input  logic           dl_wr,
	input  logic           invert_mirroring,
	loader_if.source       ld
);

	nes_pkg::loader_state_e state;

	nes_pkg::mem_addr_t addr;       // Address of the next byte
	nes_pkg::mem_addr_t bytes_left; // Bytes still due in PRG or CHR
	nes_pkg::mem_addr_t prg_bytes;
	nes_pkg::mem_addr_t chr_bytes;

	nes_pkg::byte_t prg_pages;
	nes_pkg::byte_t chr_pages;
	logic           header_ok;
	logic           accept;
	logic           last_hdr;

	ines_header_decoder ines_header_decoder_inst (
		.clk              (clk),
		.hdr_wr           (accept && (state == nes_pkg::HEADER)),
		.hdr_index        (addr[3:0]), // Header sits at addresses 0 to 15
		.hdr_byte         (dl_data),
		.invert_mirroring (invert_mirroring),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.header_ok        (header_ok),
		.flags            (ld.flags)
	);

	assign prg_bytes = nes_pkg::mem_addr_t'(prg_pages) << PRG_PAGE_BITS;
	assign chr_bytes = nes_pkg::mem_addr_t'(chr_pages) << CHR_PAGE_BITS;

	assign accept   = dl_wr && downloading;
	assign last_hdr = (addr[3:0] == 4'(nes_pkg::HEADER_LEN - 1));

	always_ff @(posedge clk) begin
		if (loader_clear) begin
			state      <= nes_pkg::HEADER;
			addr       <= '0;
			bytes_left <= '0;
		end else if (accept) begin
			addr <= addr + 22'd1;
			case (state)
				nes_pkg::HEADER: begin
					if (last_hdr) begin
						addr <= '0; // PRG starts at the bottom
						if (!header_ok) begin
							state <= nes_pkg::BAD_IMAGE;
						end else if (prg_bytes != '0) begin
							state      <= nes_pkg::PRG;
							bytes_left <= prg_bytes;
						end else if (chr_bytes != '0) begin
							state      <= nes_pkg::CHR;
							addr       <= nes_pkg::CHR_BASE;
							bytes_left <= chr_bytes;
						end else begin
							state <= nes_pkg::LOADED;
						end
					end
				end
				nes_pkg::PRG: begin
					bytes_left <= bytes_left - 22'd1;
					if (bytes_left == 22'd1) begin
						if (chr_bytes != '0) begin
							state      <= nes_pkg::CHR;
							addr       <= nes_pkg::CHR_BASE;
							bytes_left <= chr_bytes;
						end else begin
							state <= nes_pkg::LOADED; // CHR RAM cart
						end
					end
				end
				nes_pkg::CHR: begin
					bytes_left <= bytes_left - 22'd1;
					if (bytes_left == 22'd1)
						state <= nes_pkg::LOADED;
				end
				default: ; // Trailing bytes are ignored
			endcase
		end
	end

	always_comb begin
		ld.wr_addr = addr;
		ld.wr_data = dl_data;
		ld.wr_req  = accept && (state inside {nes_pkg::HEADER, nes_pkg::PRG, nes_pkg::CHR});
		ld.done    = (state == nes_pkg::LOADED) || (state == nes_pkg::BAD_IMAGE);
		ld.error   = (state == nes_pkg::BAD_IMAGE);
	end

endmodule

/* tb_nes_loader.sv */
/*
 * Testbench for the NES cartridge loader
 * Plays the golden images through the host byte port and checks memory
 * writes, mapper flags, load errors, reset timing and the joypad ports
 */
`timescale 1ns/1ps

module tb_nes_loader;

	localparam int PRG_PAGE_BITS = 4;
	localparam int CHR_PAGE_BITS = 3;
	localparam int GOLDEN_WORDS  = 512;

	logic clk = 1'b0;
	logic reset;
	logic downloading;
	nes_pkg::byte_t dl_data;
	logic dl_wr;
	logic invert_mirroring;
	nes_pkg::byte_t joy_a;
	nes_pkg::byte_t joy_b;
	logic joy_swap;
	logic joypad_strobe;
	logic [1:0] joypad_clock;
	logic nes_ce;
	logic nes_reset;
	nes_pkg::mem_addr_t mem_addr;
	nes_pkg::byte_t mem_data;
	logic mem_write;
	nes_pkg::mapper_flags_t mapper_flags;
	logic load_error;
	logic [1:0] joypad_data;

	logic [31:0] golden [GOLDEN_WORDS]; // Count, invert, error and flags of each image, then bytes
	nes_pkg::mem_addr_t exp_addr_q [$];
	nes_pkg::byte_t exp_data_q [$];
	int n_checks;
	int value_errors;
	int seq_errors;
	int cycle_cnt;
	int cycle_limit = 100000; // Replaced once the golden file is scanned
	int ce_gap;
	logic ce_seen;
	logic ce_last;
	integer seed;

	nes_loader_top #(
		.PRG_PAGE_BITS (PRG_PAGE_BITS),
		.CHR_PAGE_BITS (CHR_PAGE_BITS)
	) nes_loader_top_inst (
		.clk (clk), .reset (reset), .downloading (downloading),
		.dl_data (dl_data), .dl_wr (dl_wr), .invert_mirroring (invert_mirroring),
		.joy_a (joy_a), .joy_b (joy_b), .joy_swap (joy_swap),
		.joypad_strobe (joypad_strobe), .joypad_clock (joypad_clock),
		.nes_ce (nes_ce), .nes_reset (nes_reset), .mem_addr (mem_addr),
		.mem_data (mem_data), .mem_write (mem_write), .mapper_flags (mapper_flags),
		.load_error (load_error), .joypad_data (joypad_data)
	);

	always #5 clk = ~clk;

	task automatic check_addr(input nes_pkg::mem_addr_t got, input nes_pkg::mem_addr_t exp,
			input string what);
		n_checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_byte(input nes_pkg::byte_t got, input nes_pkg::byte_t exp,
			input string what);
		n_checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flags(input nes_pkg::mapper_flags_t got,
			input nes_pkg::mapper_flags_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		n_checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t ns %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// NES bit 7 takes host bit 0, NES bit 3 takes host bit 7
	function automatic nes_pkg::byte_t reorder_buttons(input nes_pkg::byte_t host);
		nes_pkg::byte_t nes;
		for (int i = 0; i < 4; i++) begin
			nes[7 - i] = host[i];
			nes[3 - i] = host[7 - i];
		end
		return nes;
	endfunction

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run went past %0d clock cycles", cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	// Every write must match the next expected address and byte
	always @(negedge clk) begin
		if (mem_write === 1'b1) begin
			check_bit(ce_last, 1'b1, "nes_ce in the cycle before mem_write");
			if (exp_addr_q.size() == 0) begin
				seq_errors++;
				$display("Unexpected memory write to %h at %0t ns", mem_addr, $time);
			end else begin
				check_addr(mem_addr, exp_addr_q.pop_front(), "write address");
				check_byte(mem_data, exp_data_q.pop_front(), "write data");
			end
		end
		ce_last = nes_ce;
	end

	always @(negedge clk) begin
		if (reset) begin
			ce_gap = 0;
			ce_seen = 1'b0;
		end else if (nes_ce) begin
			if (ce_seen && ce_gap != 3) begin
				seq_errors++;
				$display("nes_ce pulse came %0d cycles after the last one", ce_gap + 1);
			end
			ce_seen = 1'b1;
			ce_gap = 0;
		end else begin
			ce_gap++;
			if (ce_gap > 3) begin
				seq_errors++;
				$display("nes_ce missing for %0d cycles at %0t ns", ce_gap, $time);
			end
		end
	end

	task automatic send_byte(input nes_pkg::byte_t data, input logic wr_due,
			input nes_pkg::mem_addr_t addr);
		@(negedge clk);
		if (wr_due) begin
			exp_addr_q.push_back(addr);
			exp_data_q.push_back(data);
		end
		dl_data = data;
		dl_wr = 1'b1;
		@(negedge clk);
		dl_wr = 1'b0;
		repeat (6) @(negedge clk); // One host byte every 8 cycles
	endtask

	task automatic run_image(input int base);
		int count;
		int prg_bytes;
		int chr_bytes;
		int j;
		logic exp_err;
		logic wr_due;
		nes_pkg::mem_addr_t addr;
		count = golden[base];
		exp_err = golden[base + 2][0];
		prg_bytes = golden[base + 8][7:0] << PRG_PAGE_BITS;
		chr_bytes = golden[base + 9][7:0] << CHR_PAGE_BITS;
		@(negedge clk);
		invert_mirroring = golden[base + 1][0];
		downloading = 1'b1;
		repeat (2) @(negedge clk);
		check_bit(load_error, 1'b0, "load_error at download start");
		check_bit(nes_reset, 1'b1, "nes_reset during download");
		for (int i = 0; i < count; i++) begin
			j = i - nes_pkg::HEADER_LEN;
			wr_due = 1'b1;
			if (i < nes_pkg::HEADER_LEN)
				addr = nes_pkg::mem_addr_t'(i);
			else if (!exp_err && j < prg_bytes)
				addr = nes_pkg::mem_addr_t'(j);
			else if (!exp_err && j - prg_bytes < chr_bytes)
				addr = nes_pkg::CHR_BASE + nes_pkg::mem_addr_t'(j - prg_bytes);
			else
				wr_due = 1'b0; // Trailing bytes or a rejected image
			send_byte(golden[base + 4 + i][7:0], wr_due, addr);
		end
		// A byte past the end of the image must not reach memory
		send_byte(golden[base + 4][7:0], 1'b0, '0);
		repeat (8) @(negedge clk);
		if (exp_addr_q.size() != 0) begin
			seq_errors++;
			$display("Image at word %0d left %0d memory writes undone",
				base, exp_addr_q.size());
			exp_addr_q.delete();
			exp_data_q.delete();
		end
		check_flags(mapper_flags, golden[base + 3], "mapper_flags");
		check_bit(load_error, exp_err, "load_error");
		downloading = 1'b0;
		for (int k = 1; k <= 256; k++) begin
			@(negedge clk);
			check_bit(nes_reset, exp_err || (k < 256),
				$sformatf("nes_reset %0d cycles after load", k));
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic test_joypads;
		nes_pkg::byte_t exp_pad [2];
		for (int iter = 0; iter < 4; iter++) begin
			@(negedge clk);
			joy_a = $random(seed);
			joy_b = $random(seed);
			joy_swap = iter[0];
			joypad_strobe = 1'b1;
			@(negedge clk);
			joypad_strobe = 1'b0;
			exp_pad[0] = reorder_buttons(joy_swap ? joy_a : joy_b);
			exp_pad[1] = reorder_buttons(joy_swap ? joy_b : joy_a);
			for (int n = 0; n < 2; n++) begin
				for (int k = 0; k < 8; k++) begin
					check_bit(joypad_data[n], exp_pad[n][k],
						$sformatf("joypad port %0d bit %0d", n, k));
					check_bit(joypad_data[1 - n], (n == 0) ? exp_pad[1][0] : 1'b0,
						$sformatf("idle joypad port %0d", 1 - n));
					joypad_clock[n] = 1'b1;
					@(negedge clk);
					joypad_clock[n] = 1'b0; // Shift lands on the next rising edge
					@(negedge clk);
				end
				check_bit(joypad_data[n], 1'b0, $sformatf("joypad port %0d after 8 shifts", n));
			end
		end
	endtask

	initial begin
		int ptr;
		int n_images;
		int n_bytes;
		reset = 1'b1;
		downloading = 1'b0;
		dl_data = 8'h00;
		dl_wr = 1'b0;
		invert_mirroring = 1'b0;
		joy_a = 8'h00;
		joy_b = 8'h00;
		joy_swap = 1'b0;
		joypad_strobe = 1'b0;
		joypad_clock = 2'b00;
		seed = 32'h29f6_1c93;
		$readmemh("nes_loader_golden.hex", golden);
		ptr = 0;
		n_images = 0;
		n_bytes = 0;
		while (ptr < GOLDEN_WORDS && golden[ptr] != 32'd0) begin
			n_bytes += golden[ptr];
			n_images++;
			ptr += 4 + golden[ptr];
		end
		cycle_limit = 2 * (8 * n_bytes + 300 * n_images);
		if (n_images == 0) begin
			seq_errors++;
			$display("The golden file holds no images");
		end
		repeat (8) @(negedge clk);
		reset = 1'b0;
		for (int i = 1; i <= 16; i++) begin
			@(negedge clk);
			if (i <= 4)
				check_bit(nes_ce, i == 3, "nes_ce after reset"); // First pulse in cycle four
			check_bit(mem_write, 1'b0, "mem_write after reset");
			check_bit(load_error, 1'b0, "load_error after reset");
			check_bit(nes_reset, 1'b1, "nes_reset before first download");
			check_bit(joypad_data[0], 1'b0, "joypad port 0 after reset");
			check_bit(joypad_data[1], 1'b0, "joypad port 1 after reset");
		end
		ptr = 0;
		for (int img = 0; img < n_images; img++) begin
			run_image(ptr);
			ptr += 4 + golden[ptr];
		end
		test_joypads();
		$display("Checks: %0d, value errors: %0d, sequence errors: %0d",
			n_checks, value_errors, seq_errors);
		if (value_errors == 0 && seq_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
